// ==== rtl/svd_pkg.sv ====
// Shared field widths and step address types for the SVD step controller
package svd_pkg;

	// ----------------------------------------------------------------------
	// Field widths
	// ----------------------------------------------------------------------
	localparam int ROW_W  = 3;                    // Up to 8 rows
	localparam int COL_W  = 2;                    // Up to 4 columns
	localparam int PASS_W = 3;                    // Rotation selector
	localparam int ADR_W  = 1 + ROW_W + COL_W;    // Kind bit, row, column
	localparam int DAT_W  = 8;                    // Wishbone data word

	// ----------------------------------------------------------------------
	// Index types
	// ----------------------------------------------------------------------
	typedef logic [ROW_W-1:0]  row_t;
	typedef logic [COL_W-1:0]  col_t;
	typedef logic [PASS_W-1:0] pass_t;            // Pass p or diagonal d

	// Decoded view of a step address, MSB first on the bus
	//   [5]   is_row  1 row rotation, 0 column rotation
	//   [4:2] row index
	//   [1:0] column index
	typedef struct packed {
		logic is_row;
		row_t row;
		col_t col;
	} step_fields_t;

	// One address word, seen either raw or split into fields.
	// The sequencer fills the fields, the bus carries the flat word.
	typedef union packed {
		logic [ADR_W-1:0] flat;
		step_fields_t     fields;
	} step_adr_u;

endpackage

// ==== rtl/svd_sequencer.sv ====
// Step sequencer that walks the SVD rotation schedule, one command per step
`timescale 1ns/1ps

module svd_sequencer #(
	parameter int ROWS   = 7,
	parameter int COLS   = 4,
	parameter int SWEEPS = 16
) (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               start,
	input  logic               step_done,
	output logic               step_valid,
	output svd_pkg::step_adr_u step_adr,
	output svd_pkg::pass_t     step_pass,
	output logic               busy,
	output logic               done
);
	import svd_pkg::*;

	// ----------------------------------------------------------------------
	// Phases and schedule limits
	// ----------------------------------------------------------------------
	localparam logic [2:0] PH_IDLE = 3'd0;
	localparam logic [2:0] PH_ROW  = 3'd1;     // Triangularization, rows
	localparam logic [2:0] PH_COL  = 3'd2;     // Triangularization, columns
	localparam logic [2:0] PH_DCOL = 3'd3;     // Sweep, column at (d, d)
	localparam logic [2:0] PH_DROW = 3'd4;     // Sweep, row at (d, d)

	localparam int SW_W = (SWEEPS > 1) ? $clog2(SWEEPS) : 1;

	localparam row_t            ROW_LAST   = row_t'(ROWS - 1);
	localparam pass_t           PASS_LAST  = pass_t'(COLS - 1);
	localparam pass_t           PASS_PRE   = pass_t'(COLS - 2);   // Last diagonal too
	localparam col_t            COL_FIRST  = col_t'(COLS - 2);
	localparam logic [SW_W-1:0] SWEEP_LAST = SW_W'(SWEEPS - 1);

	logic [2:0]      phase_q;
	pass_t           pass_q;
	row_t            row_q;
	col_t            col_q;
	pass_t           diag_q;
	logic [SW_W-1:0] sweep_q;
	logic            pend_q;       // Step ready, valid follows next edge

	logic row_end;
	logic col_empty;
	logic col_end;
	logic diag_end;
	logic sweep_end;

	assign row_end   = (row_q == row_t'(pass_q));                 // Reached r == p
	assign col_empty = (pass_q >= PASS_PRE);                      // No c in (p, COLS-2]
	assign col_end   = (pass_t'(col_q) == pass_q + pass_t'(1));   // Reached c == p+1
	assign diag_end  = (diag_q == PASS_PRE);
	assign sweep_end = (sweep_q == SWEEP_LAST);

	// ----------------------------------------------------------------------
	// Current step from phase and counters
	// ----------------------------------------------------------------------
	always_comb begin
		step_adr.fields.is_row = 1'b0;
		step_adr.fields.row    = row_t'(diag_q);
		step_adr.fields.col    = col_t'(diag_q);
		step_pass              = diag_q;        // Sweeps select by d
		case (phase_q)
			PH_ROW: begin
				step_adr.fields.is_row = 1'b1;
				step_adr.fields.row    = row_q;
				step_adr.fields.col    = col_t'(pass_q);
				step_pass              = pass_q;
			end
			PH_COL: begin
				step_adr.fields.row = row_t'(pass_q);
				step_adr.fields.col = col_q;
				step_pass           = pass_q;
			end
			PH_DROW: step_adr.fields.is_row = 1'b1;
			default: ;
		endcase
	end

	// ----------------------------------------------------------------------
	// Phase FSM and counters
	// ----------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			phase_q    <= PH_IDLE;
			pass_q     <= '0;
			row_q      <= '0;
			col_q      <= '0;
			diag_q     <= '0;
			sweep_q    <= '0;
			pend_q     <= 1'b0;
			step_valid <= 1'b0;
			busy       <= 1'b0;
			done       <= 1'b0;
		end else begin
			done <= 1'b0;
			if (pend_q) begin
				step_valid <= 1'b1;
				pend_q     <= 1'b0;
			end
			if (step_valid)
				busy <= 1'b1;                   // Rises with the first bus cycle
			if (phase_q == PH_IDLE) begin
				if (start) begin
					phase_q <= PH_ROW;
					pass_q  <= '0;
					row_q   <= ROW_LAST;
					pend_q  <= 1'b1;
				end
			end else if (step_done) begin
				step_valid <= 1'b0;
				pend_q     <= 1'b1;
				case (phase_q)
					PH_ROW: begin
						if (!row_end) begin
							row_q <= row_q - row_t'(1);
						end else if (!col_empty) begin
							phase_q <= PH_COL;
							col_q   <= COL_FIRST;
						end else if (pass_q == PASS_LAST) begin
							phase_q <= PH_DCOL;       // Triangularization finished
							diag_q  <= '0;
							sweep_q <= '0;
						end else begin
							pass_q <= pass_q + pass_t'(1);
							row_q  <= ROW_LAST;
						end
					end
					PH_COL: begin
						if (!col_end) begin
							col_q <= col_q - col_t'(1);
						end else begin
							phase_q <= PH_ROW;
							pass_q  <= pass_q + pass_t'(1);
							row_q   <= ROW_LAST;
						end
					end
					PH_DCOL: phase_q <= PH_DROW;
					default: begin
						if (!diag_end) begin
							phase_q <= PH_DCOL;
							diag_q  <= diag_q + pass_t'(1);
						end else if (!sweep_end) begin
							phase_q <= PH_DCOL;
							diag_q  <= '0;
							sweep_q <= sweep_q + 1'b1;
						end else begin
							// Last sweep done, back to idle
							phase_q <= PH_IDLE;
							pend_q  <= 1'b0;
							busy    <= 1'b0;
							done    <= 1'b1;
						end
					end
				endcase
			end
		end
	end

	// ----------------------------------------------------------------------
	// Assertions
	// ----------------------------------------------------------------------
	a_shape: assert property (@(posedge clk) ROWS >= COLS)
		else $error("ROWS below COLS");

	a_fit: assert property (@(posedge clk)
		ROWS <= 2**ROW_W && COLS >= 2 && COLS <= 2**COL_W)
		else $error("Matrix size does not fit the address fields");

	a_hold: assert property (@(posedge clk) disable iff (!rst_n)
		step_valid && !step_done |=> $stable(step_adr.flat) && $stable(step_pass))
		else $error("Step changed before step_done");

endmodule

// ==== rtl/svd_wb_master.sv ====
// Wishbone classic master that writes one rotation command per bus cycle
`timescale 1ns/1ps

module svd_wb_master (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      step_valid,
	input  svd_pkg::step_adr_u        step_adr,
	input  svd_pkg::pass_t            step_pass,
	output logic                      step_done,
	output logic                      wb_cyc,
	output logic                      wb_stb,
	output logic                      wb_we,
	output svd_pkg::step_adr_u        wb_adr,
	output logic [svd_pkg::DAT_W-1:0] wb_dat_o,
	input  logic                      wb_ack
);
	import svd_pkg::*;

	logic launch;

	// Held-over valid after an ack must not open a second cycle
	assign launch = step_valid && !wb_cyc && !step_done;

	assign wb_we = 1'b1;                        // Commands are writes only

	// ----------------------------------------------------------------------
	// Bus cycle control
	// ----------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wb_cyc    <= 1'b0;
			wb_stb    <= 1'b0;
			step_done <= 1'b0;
		end else begin
			step_done <= 1'b0;
			if (launch) begin
				wb_cyc <= 1'b1;
				wb_stb <= 1'b1;
			end else if (wb_cyc && wb_ack) begin
				wb_cyc    <= 1'b0;                  // Drop on the ack edge
				wb_stb    <= 1'b0;
				step_done <= 1'b1;
			end
		end
	end

	// Address and data, captured once per cycle
	always_ff @(posedge clk) begin
		if (launch) begin
			wb_adr   <= step_adr;
			wb_dat_o <= DAT_W'(step_pass);        // Zero-extended pass index
		end
	end

	// ----------------------------------------------------------------------
	// Assertions
	// ----------------------------------------------------------------------
	a_stb_cyc: assert property (@(posedge clk) disable iff (!rst_n)
		wb_stb |-> wb_cyc)
		else $error("stb without cyc");

	a_adr_hold: assert property (@(posedge clk) disable iff (!rst_n)
		wb_stb && !wb_ack |=> $stable(wb_adr.flat) && $stable(wb_dat_o))
		else $error("Address or data moved while waiting for ack");

endmodule

// ==== rtl/svd_ctrl_top.sv ====
// SVD step controller top, schedule sequencer driving a Wishbone master
`timescale 1ns/1ps

module svd_ctrl_top #(
	parameter int ROWS   = 7,
	parameter int COLS   = 4,
	parameter int SWEEPS = 16
) (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      start,
	output logic                      busy,
	output logic                      done,
	output logic                      wb_cyc,
	output logic                      wb_stb,
	output logic                      wb_we,
	output svd_pkg::step_adr_u        wb_adr,
	output logic [svd_pkg::DAT_W-1:0] wb_dat_o,
	input  logic                      wb_ack
);
	import svd_pkg::*;

	logic      step_valid;
	logic      step_done;
	step_adr_u step_adr;
	pass_t     step_pass;

	svd_sequencer #(
		.ROWS   (ROWS),
		.COLS   (COLS),
		.SWEEPS (SWEEPS)
	) svd_sequencer_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.start      (start),
		.step_done  (step_done),
		.step_valid (step_valid),
		.step_adr   (step_adr),
		.step_pass  (step_pass),
		.busy       (busy),
		.done       (done)
	);

	svd_wb_master svd_wb_master_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.step_valid (step_valid),
		.step_adr   (step_adr),
		.step_pass  (step_pass),
		.step_done  (step_done),
		.wb_cyc     (wb_cyc),
		.wb_stb     (wb_stb),
		.wb_we      (wb_we),
		.wb_adr     (wb_adr),
		.wb_dat_o   (wb_dat_o),
		.wb_ack     (wb_ack)
	);

endmodule

// ==== tb/svd_ctrl_tb.sv ====
// Testbench for the SVD step controller, replays the step schedule against a Wishbone slave
`timescale 1ns/1ps

module svd_ctrl_tb;
	import svd_pkg::*;

	localparam int ROWS       = 4;
	localparam int COLS       = 3;
	localparam int SWEEPS     = 2;
	localparam int STEPS      = 18;       // 10 triangularization, 8 sweep steps
	localparam int FIELDS     = 5;        // Delay, is_row, row, column, pass
	localparam int MAX_DELAY  = 5;
	localparam int WAIT_LIMIT = 20;       // Negedges before a wait gives up
	localparam int QUIET      = 10;       // Idle window checked after a run

	logic                 clk = 1'b0;
	logic                 rst_n;
	logic                 start;
	logic                 busy;
	logic                 done;
	logic                 wb_cyc;
	logic                 wb_stb;
	logic                 wb_we;
	step_adr_u            wb_adr;
	logic [DAT_W-1:0]     wb_dat_o;
	logic                 wb_ack;

	logic [7:0] patterns [0:STEPS*FIELDS-1];
	integer     seed = 28602;

	always #10 clk = ~clk;                // 20 ns period

	svd_ctrl_top #(
		.ROWS   (ROWS),
		.COLS   (COLS),
		.SWEEPS (SWEEPS)
	) svd_ctrl_top_i (
		.clk      (clk),
		.rst_n    (rst_n),
		.start    (start),
		.busy     (busy),
		.done     (done),
		.wb_cyc   (wb_cyc),
		.wb_stb   (wb_stb),
		.wb_we    (wb_we),
		.wb_adr   (wb_adr),
		.wb_dat_o (wb_dat_o),
		.wb_ack   (wb_ack)
	);

	// ----------------------------------------------------------------------
	// Error reporting and compare tasks
	// ----------------------------------------------------------------------
	task automatic report_failure(input string what);
		$display("%s", what);
		$display("Something failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_adr(input string name, input step_adr_u exp, input step_adr_u act);
		if (act.flat !== exp.flat)
			report_failure($sformatf(
				"mismatch at %0t: %s expected %h (row_rot %b r %0d c %0d), actual %h",
				$time, name, exp.flat, exp.fields.is_row, exp.fields.row,
				exp.fields.col, act.flat));
	endtask

	task automatic check_pass(input string name, input pass_t exp, input pass_t act);
		if (act !== exp)
			report_failure($sformatf("mismatch at %0t: %s expected %0d, actual %0d",
				$time, name, exp, act));
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp)
			report_failure($sformatf("mismatch at %0t: %s expected %b, actual %b",
				$time, name, exp, act));
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		if (act != exp)
			report_failure($sformatf("mismatch at %0t: %s expected %0d, actual %0d",
				$time, name, exp, act));
	endtask

	// ----------------------------------------------------------------------
	// Pattern access
	// ----------------------------------------------------------------------
	task automatic load_patterns();
		int i;
		int base;
		for (i = 0; i < STEPS * FIELDS; i++)
			patterns[i] = 8'hff;             // Marks entries the file never filled
		$readmemh("tb/svd_step_patterns.txt", patterns);
		for (i = 0; i < STEPS; i++) begin
			base = i * FIELDS;
			if (patterns[base] > 8'(MAX_DELAY) || patterns[base+1] > 8'd1 ||
			    patterns[base+2] >= 8'(ROWS) || patterns[base+3] >= 8'(COLS) ||
			    patterns[base+4] >= 8'(COLS))
				report_failure($sformatf("pattern file entry for step %0d is missing or out of range",
					i));
		end
	endtask

	function automatic step_adr_u pattern_adr(input int step);
		step_adr_u a;
		a.fields.is_row = patterns[step*FIELDS+1][0];
		a.fields.row    = row_t'(patterns[step*FIELDS+2]);
		a.fields.col    = col_t'(patterns[step*FIELDS+3]);
		return a;
	endfunction

	function automatic pass_t pattern_pass(input int step);
		return pass_t'(patterns[step*FIELDS+4]);
	endfunction

	function automatic int random_delay();
		integer rnd;
		rnd = $random(seed);
		return (rnd & 32'h7fffffff) % (MAX_DELAY + 1);
	endfunction

	// ----------------------------------------------------------------------
	// Bus side of each step
	// ----------------------------------------------------------------------
	// Everything that must hold while a cycle is open
	task automatic check_bus(input step_adr_u exp_adr, input pass_t exp_pass);
		check_bit("wb_cyc", 1'b1, wb_cyc);
		check_bit("wb_stb", 1'b1, wb_stb);
		check_bit("wb_we", 1'b1, wb_we);
		check_bit("busy", 1'b1, busy);
		check_bit("done", 1'b0, done);
		check_adr("wb_adr", exp_adr, wb_adr);
		check_pass("wb_dat_o pass", exp_pass, pass_t'(wb_dat_o[PASS_W-1:0]));
		check_bit("wb_dat_o upper bits", 1'b0, |wb_dat_o[DAT_W-1:PASS_W]);
	endtask

	task automatic wait_for_cyc(input logic busy_idle, output int lows);
		lows = 0;
		@(negedge clk);
		while (!wb_cyc) begin
			check_bit("busy", busy_idle, busy);
			check_bit("done", 1'b0, done);
			check_bit("wb_stb", 1'b0, wb_stb);
			lows = lows + 1;
			if (lows > WAIT_LIMIT)
				report_failure("timed out waiting for the next bus cycle to start");
			@(negedge clk);
		end
	endtask

	task automatic run_step(input int step, input step_adr_u exp_adr, input pass_t exp_pass,
	                        input int delay, input logic pulse_start);
		int lows;
		int waited;
		wait_for_cyc((step == 0) ? 1'b0 : 1'b1, lows);
		if (step == 0)
			check_count("idle negedges from start to wb_cyc", 1, lows);
		else if (lows < 1)
			report_failure("bus cycles were less than two idle cycles apart");
		check_bus(exp_adr, exp_pass);
		if (pulse_start)
			start = 1'b1;                     // Must be ignored mid-run
		waited = 0;
		while (waited < delay) begin
			@(negedge clk);
			start = 1'b0;
			check_bus(exp_adr, exp_pass);
			waited = waited + 1;
		end
		wb_ack = 1'b1;
		@(negedge clk);
		start  = 1'b0;
		wb_ack = 1'b0;
		check_bit("wb_cyc after ack", 1'b0, wb_cyc);
		check_bit("wb_stb after ack", 1'b0, wb_stb);
	endtask

	task automatic drive_start();
		@(negedge clk);
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
		check_bit("wb_cyc", 1'b0, wb_cyc);
		check_bit("busy", 1'b0, busy);
	endtask

	task automatic finish_run();
		int waited;
		int i;
		waited = 0;
		@(negedge clk);
		while (!done) begin
			check_bit("busy before done", 1'b1, busy);
			check_bit("wb_cyc before done", 1'b0, wb_cyc);
			waited = waited + 1;
			if (waited > WAIT_LIMIT)
				report_failure("timed out waiting for done after the last ack");
			@(negedge clk);
		end
		check_bit("busy with done", 1'b0, busy);
		check_bit("wb_cyc with done", 1'b0, wb_cyc);
		@(negedge clk);
		check_bit("done one cycle later", 1'b0, done);
		for (i = 0; i < QUIET; i++) begin
			check_bit("wb_cyc after run", 1'b0, wb_cyc);
			check_bit("busy after run", 1'b0, busy);
			check_bit("done after run", 1'b0, done);
			@(negedge clk);
		end
	endtask

	task automatic run_schedule(input int run);
		int        s;
		int        delay;
		step_adr_u exp_adr;
		pass_t     exp_pass;
		drive_start();
		for (s = 0; s < STEPS; s++) begin
			exp_adr  = pattern_adr(s);
			exp_pass = pattern_pass(s);
			if (run == 0)
				delay = int'(patterns[s*FIELDS]);
			else
				delay = random_delay();
			run_step(s, exp_adr, exp_pass, delay, (run == 0) && (s == 7));
		end
		finish_run();
	endtask

	// ----------------------------------------------------------------------
	// Main sequence
	// ----------------------------------------------------------------------
	initial begin
		rst_n  = 1'b0;
		start  = 1'b0;
		wb_ack = 1'b0;
		load_patterns();
		repeat (4) @(negedge clk);
		rst_n = 1'b1;
		repeat (QUIET) begin
			@(negedge clk);
			check_bit("busy after reset", 1'b0, busy);
			check_bit("done after reset", 1'b0, done);
			check_bit("wb_cyc after reset", 1'b0, wb_cyc);   // No cycle without start
			check_bit("wb_stb after reset", 1'b0, wb_stb);
		end
		run_schedule(0);                      // Delays from the pattern file
		run_schedule(1);                      // Random delays, same steps
		$display("Everything OK");
		$finish;
	end

endmodule

// ==== tb/svd_step_patterns.txt ====
// One step per line, 4x3 matrix, two sweeps
// ack_delay is_row row col pass
1 1 3 0 0
0 1 2 0 0
3 1 1 0 0
5 1 0 0 0
2 0 0 1 0
0 1 3 1 1
4 1 2 1 1
1 1 1 1 1
2 1 3 2 2
0 1 2 2 2
3 0 0 0 0
1 1 0 0 0
5 0 1 1 1
0 1 1 1 1
2 0 0 0 0
4 1 0 0 0
1 0 1 1 1
0 1 1 1 1

// ==== files.f ====
rtl/svd_pkg.sv
rtl/svd_sequencer.sv
rtl/svd_wb_master.sv
rtl/svd_ctrl_top.sv
tb/svd_ctrl_tb.sv

// ==== Makefile ====
# Verilator build and run of the SVD step controller testbench

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert -f files.f --top-module svd_ctrl_tb \
		--Mdir obj_dir -o svd_ctrl_tb
	./obj_dir/svd_ctrl_tb

clean:
	rm -rf obj_dir
